// File: cache_hier_top.f
design/cache_pkg.sv
design/l1_icache.sv
design/l1_dcache.sv
design/l1_l2_arbiter.sv
design/l2_cache.sv
design/cache_hier_top.sv
sim/cache_hier_checker.sv
sim/cache_hier_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = cache_hier_tb
FILELIST  = cache_hier_top.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG)

check:
	@grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/cache_hier_tb.sv
// testbench top with clock, reset, line memory model, stimulus sequences and watchdog
module cache_hier_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int    L1_SETS      = 8;
    localparam int    L2_SETS      = 32;
    localparam int    RESET_CYCLES = 16;
    localparam int    MEM_LATENCY  = 3;
    localparam int    MEM_LINES    = 1024;
    localparam int    N_RANDOM     = 300;
    localparam int    N_ACCESSES   = 2 + 2 + 8 + 8 + 5 + N_RANDOM;
    localparam int    L1_STRIDE    = L1_SETS * (1 << OFFSET_BITS);
    localparam int    L2_STRIDE    = L2_SETS * (1 << OFFSET_BITS);
    localparam word_t FILL_KEY     = 32'h5a3c_96e1;
    localparam addr_t I_BASE       = 32'h0000_0000;
    localparam addr_t D_BASE       = 32'h0000_2000;

    logic       clk;
    logic       arst_n_i;
    addr_t      i_addr_i;
    logic       i_rd_i;
    logic       i_stall_o;
    word_t      i_rdata_o;
    addr_t      d_addr_i;
    logic       d_rd_i;
    logic       d_wr_i;
    word_t      d_wdata_i;
    logic       d_stall_o;
    word_t      d_rdata_o;
    logic       mem_rd_o;
    logic       mem_wr_o;
    line_addr_t mem_addr_o;
    line_t      mem_wdata_o;
    line_t      mem_rdata_i;
    logic       mem_ready_i;
    logic       l1i_miss_o;
    logic       l1d_miss_o;
    logic       l2_miss_o;
    line_t      mem [MEM_LINES];

    cache_hier_top #(.L1_SETS(L1_SETS), .L2_SETS(L2_SETS)) UUT (.*);

    cache_hier_checker #(.FILL_KEY(FILL_KEY)) u_checker (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .i_addr_i   (i_addr_i),
        .i_rd_i     (i_rd_i),
        .i_stall_i  (i_stall_o),
        .i_rdata_i  (i_rdata_o),
        .d_addr_i   (d_addr_i),
        .d_rd_i     (d_rd_i),
        .d_wr_i     (d_wr_i),
        .d_wdata_i  (d_wdata_i),
        .d_stall_i  (d_stall_o),
        .d_rdata_i  (d_rdata_o),
        .mem_wr_i   (mem_wr_o),
        .l1i_miss_i (l1i_miss_o),
        .l1d_miss_i (l1d_miss_o),
        .l2_miss_i  (l2_miss_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // line memory, answers a held request level after MEM_LATENCY cycles
    initial begin : line_memory
        int wait_cycles;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        wait_cycles = 0;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem[l][w*WORD_BITS +: WORD_BITS] = word_t'(l * 16 + w * 4) ^ FILL_KEY;
            end
        end
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready_i) begin
                mem_ready_i = 1'b0;
                wait_cycles = 0;
            end else if (mem_rd_o || mem_wr_o) begin
                wait_cycles++;
                if (wait_cycles == MEM_LATENCY) begin
                    if (mem_wr_o) begin
                        mem[mem_addr_o[$clog2(MEM_LINES)-1:0]] = mem_wdata_o;
                    end else begin
                        mem_rdata_i = mem[mem_addr_o[$clog2(MEM_LINES)-1:0]];
                    end
                    mem_ready_i = 1'b1;
                end
            end
        end
    end

    task automatic i_read(input addr_t a);
        i_addr_i = a;
        i_rd_i   = 1'b1;
        do begin
            @(negedge clk);
        end while (i_stall_o);
        @(posedge clk);
        #1;
        i_rd_i = 1'b0;
    endtask

    task automatic d_access(input logic wr, input addr_t a, input word_t wd);
        d_addr_i  = a;
        d_wdata_i = wd;
        d_wr_i    = wr;
        d_rd_i    = !wr;
        do begin
            @(negedge clk);
        end while (d_stall_o);
        @(posedge clk);
        #1;
        d_rd_i = 1'b0;
        d_wr_i = 1'b0;
    endtask

    initial begin : watchdog
        repeat (RESET_CYCLES + 200 * N_ACCESSES) @(posedge clk);
        $display("watchdog expired, an access never completed");
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        int kind;
        arst_n_i  = 1'b0;
        i_addr_i  = '0;
        i_rd_i    = 1'b0;
        d_addr_i  = '0;
        d_rd_i    = 1'b0;
        d_wr_i    = 1'b0;
        d_wdata_i = '0;
        void'($urandom(32'hde0e_0909));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(posedge clk);
        #1;

        // one cold line, missing in both levels
        u_checker.start_test("cold_i_read");
        i_read(I_BASE + 32'h40);
        i_read(I_BASE + 32'h44);
        u_checker.check_miss_counts(1, 0, 1);
        u_checker.end_test();

        // write miss refills a cold line, then the read hits
        u_checker.start_test("d_write_read");
        d_access(1'b1, D_BASE + 32'h100, $urandom);
        d_access(1'b0, D_BASE + 32'h100, '0);
        u_checker.check_miss_counts(0, 1, 1);
        u_checker.end_test();

        // same L1 set, different L2 sets
        u_checker.start_test("l1_conflict");
        for (int k = 0; k < 4; k++) begin
            d_access(1'b1, D_BASE + 32'h400 + k * L1_STRIDE, $urandom);
        end
        for (int k = 0; k < 4; k++) begin
            d_access(1'b0, D_BASE + 32'h400 + k * L1_STRIDE, '0);
        end
        u_checker.end_test();

        u_checker.start_test("l2_conflict");
        for (int k = 0; k < 4; k++) begin
            d_access(1'b1, D_BASE + 32'h1040 + k * L2_STRIDE, $urandom);
        end
        for (int k = 0; k < 4; k++) begin
            d_access(1'b0, D_BASE + 32'h1040 + k * L2_STRIDE, '0);
        end
        u_checker.check_mem_writes();
        u_checker.end_test();

        u_checker.start_test("i_d_same_cycle");
        fork
            i_read(I_BASE + 32'h800);
            d_access(1'b0, D_BASE + 32'h1800, '0);
        join
        fork
            i_read(I_BASE + 32'h904);
            d_access(1'b1, D_BASE + 32'h1908, $urandom);
        join
        d_access(1'b0, D_BASE + 32'h1908, '0);
        u_checker.end_test();

        u_checker.start_test("random_mix");
        for (int n = 0; n < N_RANDOM; n++) begin
            kind = int'($urandom % 3);
            if (kind == 0) begin
                i_read(I_BASE | ($urandom & 32'h0ffc));
            end else begin
                d_access(kind == 1, D_BASE | ($urandom & 32'h07fc), $urandom);
            end
        end
        u_checker.end_test();

        u_checker.report();
        if (u_checker.err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim/cache_hier_checker.sv
// checker with shadow memory, reference function, read and miss count comparisons and result report
module cache_hier_checker #(
    parameter cache_pkg::word_t FILL_KEY = 32'h0
) (
    input logic             clk,
    input logic             arst_n_i,
    input cache_pkg::addr_t i_addr_i,
    input logic             i_rd_i,
    input logic             i_stall_i,
    input cache_pkg::word_t i_rdata_i,
    input cache_pkg::addr_t d_addr_i,
    input logic             d_rd_i,
    input logic             d_wr_i,
    input cache_pkg::word_t d_wdata_i,
    input logic             d_stall_i,
    input cache_pkg::word_t d_rdata_i,
    input logic             mem_wr_i,
    input logic             l1i_miss_i,
    input logic             l1d_miss_i,
    input logic             l2_miss_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    word_t shadow [addr_t];
    string cur_test      = "none";
    int    tests_run     = 0;
    int    test_reads    = 0;
    int    test_errs     = 0;
    int    total_reads   = 0;
    int    err_count     = 0;
    int    i_misses      = 0;
    int    d_misses      = 0;
    int    l2_misses     = 0;
    int    mem_wr_cycles = 0;

    // untouched words still hold the memory preload pattern
    function automatic word_t expected_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_KEY;
    endfunction

    task automatic compare_read(input string side, input addr_t a, input word_t act);
        word_t want;
        want = expected_word(a);
        test_reads++;
        total_reads++;
        if (act !== want) begin
            $display("ERR %s: %s read at %h expected %h actual %h",
                     cur_test, side, a, want, act);
            test_errs++;
            err_count++;
        end
    endtask

    // an access completes in the cycle its request is present with stall low
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (l1i_miss_i) begin
                i_misses++;
            end
            if (l1d_miss_i) begin
                d_misses++;
            end
            if (l2_miss_i) begin
                l2_misses++;
            end
            if (mem_wr_i) begin
                mem_wr_cycles++;
            end
            if (i_rd_i && !i_stall_i) begin
                compare_read("I", i_addr_i, i_rdata_i);
            end
            if (d_rd_i && !d_stall_i) begin
                compare_read("D", d_addr_i, d_rdata_i);
            end
            if (d_wr_i && !d_stall_i) begin
                shadow[d_addr_i] = d_wdata_i;
            end
        end
    end

    task automatic start_test(input string name);
        cur_test      = name;
        test_reads    = 0;
        test_errs     = 0;
        i_misses      = 0;
        d_misses      = 0;
        l2_misses     = 0;
        mem_wr_cycles = 0;
    endtask

    task automatic compare_count(input string what, input int want, input int act);
        if (act != want) begin
            $display("ERR %s: %s expected %0d actual %0d", cur_test, what, want, act);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic check_miss_counts(input int want_i, input int want_d, input int want_l2);
        compare_count("l1i miss pulses", want_i, i_misses);
        compare_count("l1d miss pulses", want_d, d_misses);
        compare_count("l2 miss pulses", want_l2, l2_misses);
    endtask

    task automatic check_mem_writes();
        if (mem_wr_cycles == 0) begin
            $display("%s: no writeback to memory was seen", cur_test);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-16s %s: %0d reads checked, %0d errors", cur_test,
                 (test_errs == 0) ? "ok" : "failed", test_reads, test_errs);
    endtask

    task automatic report();
        $display("done: %0d tests, %0d reads checked, %0d errors",
                 tests_run, total_reads, err_count);
    endtask

endmodule

// File: design/cache_hier_top.sv
// top level wiring of the instruction and data L1s, the arbiter and the unified L2
module cache_hier_top #(
    parameter int L1_SETS = 8,
    parameter int L2_SETS = 32
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  cache_pkg::addr_t      i_addr_i,
    input  logic                  i_rd_i,
    output logic                  i_stall_o,
    output cache_pkg::word_t      i_rdata_o,
    input  cache_pkg::addr_t      d_addr_i,
    input  logic                  d_rd_i,
    input  logic                  d_wr_i,
    input  cache_pkg::word_t      d_wdata_i,
    output logic                  d_stall_o,
    output cache_pkg::word_t      d_rdata_o,
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output cache_pkg::line_addr_t mem_addr_o,
    output cache_pkg::line_t      mem_wdata_o,
    input  cache_pkg::line_t      mem_rdata_i,
    input  logic                  mem_ready_i,
    output logic                  l1i_miss_o,
    output logic                  l1d_miss_o,
    output logic                  l2_miss_o
);
    import cache_pkg::*;

    logic       l1i_rd;
    line_addr_t l1i_addr;
    logic       l1i_rdy;
    logic       l1d_rd;
    logic       l1d_wr;
    line_addr_t l1d_addr;
    line_t      l1d_wdata;
    logic       l1d_rdy;
    logic       l2_rd;
    logic       l2_wr;
    line_addr_t l2_addr;
    line_t      l2_wdata;
    line_t      l2_rdata;
    logic       l2_rdy;

    l1_icache #(.L1_SETS(L1_SETS)) u_l1_icache (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .addr_i     (i_addr_i),
        .rd_i       (i_rd_i),
        .stall_o    (i_stall_o),
        .rdata_o    (i_rdata_o),
        .l2_rd_o    (l1i_rd),
        .l2_addr_o  (l1i_addr),
        .l2_rdata_i (l2_rdata),
        .l2_rdy_i   (l1i_rdy),
        .miss_o     (l1i_miss_o)
    );

    l1_dcache #(.L1_SETS(L1_SETS)) u_l1_dcache (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .addr_i     (d_addr_i),
        .rd_i       (d_rd_i),
        .wr_i       (d_wr_i),
        .wdata_i    (d_wdata_i),
        .stall_o    (d_stall_o),
        .rdata_o    (d_rdata_o),
        .l2_rd_o    (l1d_rd),
        .l2_wr_o    (l1d_wr),
        .l2_addr_o  (l1d_addr),
        .l2_wdata_o (l1d_wdata),
        .l2_rdata_i (l2_rdata),
        .l2_rdy_i   (l1d_rdy),
        .miss_o     (l1d_miss_o)
    );

    l1_l2_arbiter u_l1_l2_arbiter (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .i_rd_i    (l1i_rd),
        .i_addr_i  (l1i_addr),
        .i_rdy_o   (l1i_rdy),
        .d_rd_i    (l1d_rd),
        .d_wr_i    (l1d_wr),
        .d_addr_i  (l1d_addr),
        .d_wdata_i (l1d_wdata),
        .d_rdy_o   (l1d_rdy),
        .rd_o      (l2_rd),
        .wr_o      (l2_wr),
        .addr_o    (l2_addr),
        .wdata_o   (l2_wdata),
        .rdy_i     (l2_rdy)
    );

    l2_cache #(.L2_SETS(L2_SETS)) u_l2_cache (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_i        (l2_rd),
        .wr_i        (l2_wr),
        .addr_i      (l2_addr),
        .wdata_i     (l2_wdata),
        .rdata_o     (l2_rdata),
        .rdy_o       (l2_rdy),
        .mem_rd_o    (mem_rd_o),
        .mem_wr_o    (mem_wr_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i),
        .miss_o      (l2_miss_o)
    );

endmodule

// File: design/l2_cache.sv
// direct-mapped write-back unified L2 with memory writeback and line refill
module l2_cache #(
    parameter int L2_SETS = 32
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  cache_pkg::line_addr_t addr_i,
    input  cache_pkg::line_t      wdata_i,
    output cache_pkg::line_t      rdata_o,
    output logic                  rdy_o,
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output cache_pkg::line_addr_t mem_addr_o,
    output cache_pkg::line_t      mem_wdata_o,
    input  cache_pkg::line_t      mem_rdata_i,
    input  logic                  mem_ready_i,
    output logic                  miss_o
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(L2_SETS);
    localparam int TAG_BITS = LINE_ADDR_BITS - IDX_BITS;

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_RESP, S_WB, S_FILL} state_e;

    state_e              state_q;
    state_e              state_d;
    logic [L2_SETS-1:0]  valid_q;
    logic [L2_SETS-1:0]  dirty_q;
    logic [TAG_BITS-1:0] tags_q [L2_SETS];
    line_t               lines_q [L2_SETS];
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    logic                hit;
    logic                victim_dirty;
    logic                store_wr;
    logic                fill_done;

    assign idx          = addr_i[IDX_BITS-1:0];
    assign tag          = addr_i[LINE_ADDR_BITS-1:IDX_BITS];
    assign hit          = valid_q[idx] && (tags_q[idx] == tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx] && !hit;

    // a write carries the whole line, so it allocates once the victim is clean
    assign store_wr  = wr_i && (((state_q == S_LOOKUP) && !victim_dirty) ||
                                ((state_q == S_WB) && mem_ready_i));
    assign fill_done = (state_q == S_FILL) && mem_ready_i;

    assign rdy_o       = (state_q == S_RESP);
    assign rdata_o     = lines_q[idx];
    assign miss_o      = (state_q == S_LOOKUP) && !hit;
    assign mem_wr_o    = (state_q == S_WB);
    assign mem_rd_o    = (state_q == S_FILL);
    assign mem_addr_o  = mem_wr_o ? {tags_q[idx], idx} : addr_i;
    assign mem_wdata_o = lines_q[idx];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (rd_i || wr_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (victim_dirty) begin
                    state_d = S_WB;
                end else if (hit || wr_i) begin
                    state_d = S_RESP;
                end else begin
                    state_d = S_FILL;
                end
            end
            S_WB: begin
                if (mem_ready_i) begin
                    state_d = wr_i ? S_RESP : S_FILL;
                end
            end
            S_FILL: begin
                if (mem_ready_i) begin
                    state_d = S_RESP;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (store_wr || fill_done) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= store_wr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_wr || fill_done) begin
            tags_q[idx]  <= tag;
            lines_q[idx] <= store_wr ? wdata_i : mem_rdata_i;
        end
    end

    // memory traffic serves an open L1 request and never reads with a write
    a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mem_rd_o && mem_wr_o) && (!(mem_rd_o || mem_wr_o) || rd_i || wr_i))
        else $error("l2_cache: bad memory access");

    // the L1 side keeps its request up until the ready pulse
    a_req_to_rdy: assert property (@(posedge clk) disable iff (!arst_n_i)
        rdy_o |-> (rd_i || wr_i))
        else $error("l2_cache: request dropped before rdy_o");

endmodule

// File: design/l1_l2_arbiter.sv
// arbiter merging the instruction and data L1 request streams onto the L2 port
module l1_l2_arbiter (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  i_rd_i,
    input  cache_pkg::line_addr_t i_addr_i,
    output logic                  i_rdy_o,
    input  logic                  d_rd_i,
    input  logic                  d_wr_i,
    input  cache_pkg::line_addr_t d_addr_i,
    input  cache_pkg::line_t      d_wdata_i,
    output logic                  d_rdy_o,
    output logic                  rd_o,
    output logic                  wr_o,
    output cache_pkg::line_addr_t addr_o,
    output cache_pkg::line_t      wdata_o,
    input  logic                  rdy_i
);
    logic d_req;
    logic busy_q;
    logic gnt_d_q;
    logic sel_d;

    assign d_req = d_rd_i || d_wr_i;

    // an open transfer keeps its owner, a fresh one goes to D first
    assign sel_d = busy_q ? gnt_d_q : d_req;

    assign rd_o    = sel_d ? d_rd_i : i_rd_i;
    assign wr_o    = sel_d && d_wr_i;
    assign addr_o  = sel_d ? d_addr_i : i_addr_i;
    assign wdata_o = d_wdata_i;
    assign d_rdy_o = rdy_i && sel_d;
    assign i_rdy_o = rdy_i && !sel_d;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            gnt_d_q <= 1'b0;
        end else if (rdy_i) begin
            busy_q <= 1'b0;
        end else if (!busy_q && (rd_o || wr_o)) begin
            busy_q  <= 1'b1;
            gnt_d_q <= sel_d;
        end
    end

    // ready reaches exactly one side, and that side still holds its request
    a_rdy_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(i_rdy_o && d_rdy_o) && (!i_rdy_o || i_rd_i) && (!d_rdy_o || d_req))
        else $error("l1_l2_arbiter: ready routed to the wrong L1");

endmodule

// File: design/l1_dcache.sv
// direct-mapped write-back data L1 with dirty victim eviction and refill
module l1_dcache #(
    parameter int L1_SETS = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  cache_pkg::addr_t      addr_i,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  cache_pkg::word_t      wdata_i,
    output logic                  stall_o,
    output cache_pkg::word_t      rdata_o,
    output logic                  l2_rd_o,
    output logic                  l2_wr_o,
    output cache_pkg::line_addr_t l2_addr_o,
    output cache_pkg::line_t      l2_wdata_o,
    input  cache_pkg::line_t      l2_rdata_i,
    input  logic                  l2_rdy_i,
    output logic                  miss_o
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(L1_SETS);
    localparam int TAG_BITS = LINE_ADDR_BITS - IDX_BITS;

    typedef enum logic [1:0] {S_IDLE, S_WB, S_FILL} state_e;

    state_e                   state_q;
    state_e                   state_d;
    logic [L1_SETS-1:0]       valid_q;
    logic [L1_SETS-1:0]       dirty_q;
    logic [TAG_BITS-1:0]      tags_q [L1_SETS];
    line_t                    lines_q [L1_SETS];
    line_addr_t               line_addr;
    logic [IDX_BITS-1:0]      idx;
    logic [TAG_BITS-1:0]      tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     hit;
    logic                     wr_hit;
    logic                     fill_done;

    assign line_addr = addr_i[ADDR_BITS-1:OFFSET_BITS];
    assign idx       = line_addr[IDX_BITS-1:0];
    assign tag       = line_addr[LINE_ADDR_BITS-1:IDX_BITS];
    assign word_sel  = addr_i[OFFSET_BITS-1:OFFSET_BITS-WORD_SEL_BITS];
    assign hit       = valid_q[idx] && (tags_q[idx] == tag);

    assign stall_o   = (rd_i || wr_i) && !hit;
    assign rdata_o   = lines_q[idx][word_sel*WORD_BITS +: WORD_BITS];
    assign miss_o    = (state_q == S_IDLE) && stall_o;
    assign wr_hit    = (state_q == S_IDLE) && wr_i && hit;
    assign fill_done = (state_q == S_FILL) && l2_rdy_i;

    assign l2_wr_o    = (state_q == S_WB);
    assign l2_rd_o    = (state_q == S_FILL);
    // victim goes out under its own line address
    assign l2_addr_o  = l2_wr_o ? {tags_q[idx], idx} : line_addr;
    assign l2_wdata_o = lines_q[idx];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (stall_o) begin
                    state_d = (valid_q[idx] && dirty_q[idx]) ? S_WB : S_FILL;
                end
            end
            S_WB: begin
                if (l2_rdy_i) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (l2_rdy_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (wr_hit) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags_q[idx]  <= tag;
            lines_q[idx] <= l2_rdata_i;
        end else if (wr_hit) begin
            lines_q[idx][word_sel*WORD_BITS +: WORD_BITS] <= wdata_i;
        end
    end

    // L2 traffic only under a stalled core request and never read with write
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(l2_rd_o && l2_wr_o) && (!(l2_rd_o || l2_wr_o) || stall_o))
        else $error("l1_dcache: bad request toward L2");

endmodule

// File: design/l1_icache.sv
// direct-mapped read-only instruction L1 with line refill from L2
module l1_icache #(
    parameter int L1_SETS = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  cache_pkg::addr_t      addr_i,
    input  logic                  rd_i,
    output logic                  stall_o,
    output cache_pkg::word_t      rdata_o,
    output logic                  l2_rd_o,
    output cache_pkg::line_addr_t l2_addr_o,
    input  cache_pkg::line_t      l2_rdata_i,
    input  logic                  l2_rdy_i,
    output logic                  miss_o
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(L1_SETS);
    localparam int TAG_BITS = LINE_ADDR_BITS - IDX_BITS;

    logic [L1_SETS-1:0]       valid_q;
    logic [TAG_BITS-1:0]      tags_q [L1_SETS];
    line_t                    lines_q [L1_SETS];
    line_addr_t               line_addr;
    logic [IDX_BITS-1:0]      idx;
    logic [TAG_BITS-1:0]      tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     hit;
    logic                     req_q;

    assign line_addr = addr_i[ADDR_BITS-1:OFFSET_BITS];
    assign idx       = line_addr[IDX_BITS-1:0];
    assign tag       = line_addr[LINE_ADDR_BITS-1:IDX_BITS];
    assign word_sel  = addr_i[OFFSET_BITS-1:OFFSET_BITS-WORD_SEL_BITS];
    assign hit       = valid_q[idx] && (tags_q[idx] == tag);

    assign stall_o   = rd_i && !hit;
    assign rdata_o   = lines_q[idx][word_sel*WORD_BITS +: WORD_BITS];

    // the core holds the address, so the miss itself is the request level
    assign l2_rd_o   = stall_o;
    assign l2_addr_o = line_addr;
    assign miss_o    = l2_rd_o && !req_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            req_q   <= 1'b0;
        end else begin
            req_q <= l2_rd_o && !l2_rdy_i;
            if (l2_rd_o && l2_rdy_i) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (l2_rd_o && l2_rdy_i) begin
            tags_q[idx]  <= tag;
            lines_q[idx] <= l2_rdata_i;
        end
    end

    // refill request survives until L2 answers
    a_rd_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        l2_rd_o && !l2_rdy_i |=> l2_rd_o)
        else $error("l1_icache: l2_rd_o dropped before l2_rdy_i");

endmodule

// File: design/cache_pkg.sv
// address, word and line types plus field widths shared by the cache hierarchy
package cache_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;

    // byte offset inside a line
    localparam int OFFSET_BITS    = 4;

    // word select, the upper part of the byte offset
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);

    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;

    typedef logic [WORD_BITS-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_BITS-1:0] line_t;

    // byte address without the offset, exchanged between the levels
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

endpackage
